// File: adpcmb_channel.f
design/adpcmb_pkg.sv
design/adpcmb_fetch.sv
design/adpcmb_decoder.sv
design/adpcmb_output.sv
design/adpcmb_channel.sv
testbench/adpcmb_properties.sv
testbench/adpcmb_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= adpcmb_tb
FILELIST  ?= adpcmb_channel.f
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "Simulation failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/adpcmb_tb.sv
// 4 KiB memory model, addr_w 12; random cen about 75% high, fixed seed, stops at first error
`timescale 1ns/1ps

module adpcmb_tb;
    import adpcmb_pkg::*;

    localparam logic [31:0] seed = 32'h5053f3c5;

    logic        clk;
    logic        rst_n;
    logic        cen;
    logic        key_on;
    logic        key_off;
    logic        repeat_en;
    logic [11:0] start_addr;
    logic [11:0] end_addr;
    delta_t      delta;
    level_t      level;
    pan_t        pan;
    logic [11:0] mem_addr;
    byte_t       mem_data;
    pcm_t        left;
    pcm_t        right;
    logic        sample_stb;
    logic        playing;
    logic        eos;

    byte_t       mem [0:4095];
    logic [31:0] rng;                       // main stimulus stream
    logic [31:0] cen_rng;                   // cen stream, kept apart
    logic        was_en;                    // cen at the last rising edge
    int          eos_cnt;
    int          m_x;                       // model waveform
    int          m_step;                    // model step

    adpcmb_channel #(.addr_w(12)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous read, data appears 1 ns after the edge like the other inputs
    always @(posedge clk) begin
        byte_t rd;
        rd = mem[mem_addr];
        #1;
        mem_data = rd;
    end

    // count eos once per enabled edge it was set on
    always @(posedge clk) begin
        logic en;
        en = cen;
        #1;
        if (en && eos) eos_cnt++;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_pcm(input string name, input pcm_t exp, input pcm_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // one clock, inputs change 1 ns later
    task automatic step();
        @(posedge clk);
        was_en = cen;
        #1;
    endtask

    task automatic pulse_key(input logic off);
        int n;
        n = 0;
        if (off) key_off = 1'b1;
        else key_on = 1'b1;
        do begin
            step();
            n++;
            if (n > 2000) timed_out("an enabled cycle for the key strobe");
        end while (!was_en);
        key_on  = 1'b0;
        key_off = 1'b0;
    endtask

    task automatic wait_stb(input string name);
        int n;
        n = 0;
        do begin
            step();
            n++;
            if (n > 2000) timed_out({"sample_stb in ", name});
        end while (!(was_en && sample_stb));
    endtask

    task automatic model_clear();
        m_x    = 0;
        m_step = 127;
    endtask

    // reference decoder, one nibble
    task automatic model_decode(input nibble_t n);
        int mag;
        int d;
        int f;
        mag = int'(n[2:0]);
        d = ((2 * mag + 1) * m_step) / 8;
        if (n[3]) d = -d;
        m_x = m_x + d;
        if (m_x > 32767) m_x = 32767;
        if (m_x < -32768) m_x = -32768;
        case (mag)
            4: f = 77;
            5: f = 102;
            6: f = 128;
            7: f = 153;
            default: f = 57;
        endcase
        m_step = (m_step * f) / 64;
        if (m_step < 127) m_step = 127;
        if (m_step > 24576) m_step = 24576;
    endtask

    function automatic pcm_t scale(input int x, input level_t lv, input logic en);
        if (!en) return '0;
        return pcm_t'((x * int'(lv)) >>> 8);
    endfunction

    function automatic nibble_t nibble_at(input int base, input int k);
        byte_t b;
        b = mem[base + k / 2];
        return (k % 2 == 0) ? b[7:4] : b[3:0];   // high half first
    endfunction

    // key on and compare nsamp samples against the model, wrapping on repeat
    task automatic play(input string name, input int base, input int len, input level_t lv,
                        input pan_t pn, input logic rep, input int nsamp);
        int k;
        start_addr = 12'(base);
        end_addr   = 12'(base + len - 1);
        repeat_en  = rep;
        level      = lv;
        pan        = pn;
        delta      = delta_t'(4000 + next_rand() % 6923);   // legal range only
        eos_cnt    = 0;
        model_clear();
        pulse_key(1'b0);
        for (k = 0; k < nsamp; k++) begin
            wait_stb(name);
            if (k % (2 * len) == 0) model_clear();   // start and each loop
            model_decode(nibble_at(base, k % (2 * len)));
            check_pcm({name, " left"}, scale(m_x, lv, pn.left), left);
            check_pcm({name, " right"}, scale(m_x, lv, pn.right), right);
        end
    endtask

    task automatic quiet_after(input string name, input int exp_eos);
        int n;
        for (n = 0; n < 40; n++) begin
            step();
            check_bit({name, " no extra strobe"}, 1'b0, was_en && sample_stb);
        end
        check_bit({name, " playing"}, 1'b0, playing);
        check_count({name, " eos count"}, exp_eos, eos_cnt);
        check_pcm({name, " left cleared"}, '0, left);
        check_pcm({name, " right cleared"}, '0, right);
    endtask

    task automatic finish_end(input string name);
        int n;
        n = 0;
        while (playing) begin
            step();
            n++;
            if (n > 2000) timed_out({"playing to drop in ", name});
        end
        quiet_after(name, 1);
    endtask

    initial begin
        int i;
        logic [31:0] r;
        rst_n      = 1'b1;
        cen        = 1'b0;
        key_on     = 1'b0;
        key_off    = 1'b0;
        repeat_en  = 1'b0;
        start_addr = '0;
        end_addr   = '0;
        delta      = '0;
        level      = '0;
        pan        = '0;
        mem_data   = '0;
        eos_cnt    = 0;
        rng        = seed;
        cen_rng    = seed;
        for (i = 0; i < 4096; i++) begin
            r = next_rand();
            mem[i] = r[7:0];
        end
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        play("decode", 16, 200, 8'd255, '{1'b1, 1'b1}, 1'b0, 400);
        finish_end("decode");   // 400 strobes for 200 bytes, then one eos

        for (i = 0; i < 4; i++) begin
            r = next_rand();
            play("level pan", 512 + 32 * i, 16, r[7:0], pan_t'(i), 1'b0, 32);
            finish_end("level pan");
        end

        play("repeat", 800, 8, 8'd200, '{1'b1, 1'b1}, 1'b1, 48);
        pulse_key(1'b1);
        quiet_after("repeat stop", 0);

        for (i = 1024; i < 1056; i++) mem[i] = 8'h77;
        play("saturate high", 1024, 32, 8'd255, '{1'b1, 1'b1}, 1'b0, 64);
        check_pcm("saturate high end", pcm_t'((32767 * 255) >>> 8), right);
        finish_end("saturate high");
        for (i = 1024; i < 1056; i++) mem[i] = 8'hff;
        play("saturate low", 1024, 32, 8'd255, '{1'b1, 1'b1}, 1'b0, 64);
        check_pcm("saturate low end", pcm_t'((-32768 * 255) >>> 8), left);
        finish_end("saturate low");

        play("key off", 2048, 40, 8'd180, '{1'b1, 1'b0}, 1'b0, 5);
        pulse_key(1'b1);
        quiet_after("key off", 0);
        play("key on again", 2048, 40, 8'd180, '{1'b1, 1'b0}, 1'b0, 80);
        finish_end("key on again");

        $display("Simulation passed");
        $finish;
    end

    // random cen, high on 3 of 4 codes
    initial begin
        forever begin
            @(posedge clk);
            #1;
            cen_rng = xorshift(cen_rng);
            cen = (cen_rng[1:0] != 2'b00);
        end
    end

endmodule

// File: testbench/adpcmb_properties.sv
// bound into adpcmb_channel; counts enabled cycles only, so cen gaps are ignored
`timescale 1ns/1ps

module adpcmb_properties (
    input logic clk,
    input logic rst_n,
    input logic cen,
    input logic adv,
    input logic upd,
    input logic chon,
    input logic clr,
    input logic eos,
    input logic sample_stb
);
    logic [2:0] since_adv;                  // enabled edges since adv was last seen, saturating
    logic [4:0] adv_hist;                   // adv as seen on recent enabled edges

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_adv <= 3'd7;
            adv_hist  <= '0;
        end else if (cen) begin
            adv_hist  <= {adv_hist[3:0], adv};
            if (adv) since_adv <= 3'd1;
            else if (since_adv != 3'd7) since_adv <= since_adv + 3'd1;
        end
    end

    // nibble requests must leave room for the decoder pipeline
    a_adv_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && adv) |-> (since_adv >= 3'd6)) else $error("adv pulses too close");

    // every upd belongs to the adv seen 5 enabled edges before
    a_upd_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && upd) |-> adv_hist[4]) else $error("upd without matching adv");

    a_reset_vals: assert property (@(posedge clk)
        !rst_n |-> !(adv || upd || chon || clr || eos || sample_stb))
        else $error("control output high in reset");

    // fetch counts its own drain cycles, the end must land on the last decode
    a_eos_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(eos) |-> ($fell(chon) && upd))
        else $error("eos without chon falling on the last upd");

endmodule

bind adpcmb_channel adpcmb_properties u_props (
    .clk, .rst_n, .cen, .adv, .upd, .chon, .clr, .eos, .sample_stb
);

// File: design/adpcmb_channel.sv
// one ADPCM-B voice; sample memory must be synchronous read, delta limited to 10922
`timescale 1ns/1ps

module adpcmb_channel #(
    parameter int addr_w = adpcmb_pkg::default_addr_w    // 8 or more
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,            // everything advances on enabled cycles only
    input  logic                key_on,
    input  logic                key_off,
    input  logic                repeat_en,
    input  logic [addr_w-1:0]   start_addr,
    input  logic [addr_w-1:0]   end_addr,
    input  adpcmb_pkg::delta_t  delta,
    input  adpcmb_pkg::level_t  level,
    input  adpcmb_pkg::pan_t    pan,
    output logic [addr_w-1:0]   mem_addr,
    input  adpcmb_pkg::byte_t   mem_data,
    output adpcmb_pkg::pcm_t    left,
    output adpcmb_pkg::pcm_t    right,
    output logic                sample_stb,
    output logic                playing,
    output logic                eos
);
    import adpcmb_pkg::*;

    nibble_t nibble;
    logic    adv;
    logic    chon;
    logic    clr;
    pcm_t    pcm;
    logic    upd;

    assign playing = chon;

    adpcmb_fetch #(.addr_w(addr_w)) u_fetch (
        .clk, .rst_n, .cen,
        .key_on, .key_off, .repeat_en,
        .start_addr, .end_addr, .delta,
        .mem_data, .mem_addr,
        .nibble, .adv, .chon, .clr, .eos
    );

    adpcmb_decoder u_decoder (
        .clk, .rst_n, .cen,
        .nibble, .adv, .chon, .clr,
        .pcm, .upd
    );

    adpcmb_output u_output (
        .clk, .rst_n, .cen,
        .pcm, .upd, .chon,
        .level, .pan,
        .left, .right, .sample_stb
    );

endmodule

// File: design/adpcmb_output.sv
// registered one enabled cycle after upd; no hold-off, the sample strobe must be taken when it comes
`timescale 1ns/1ps

module adpcmb_output (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcmb_pkg::pcm_t    pcm,
    input  logic                upd,        // new waveform value
    input  logic                chon,
    input  adpcmb_pkg::level_t  level,
    input  adpcmb_pkg::pan_t    pan,
    output adpcmb_pkg::pcm_t    left,
    output adpcmb_pkg::pcm_t    right,
    output logic                sample_stb
);
    import adpcmb_pkg::*;

    logic signed [24:0] prod;               // 16 x 9 bit signed
    pcm_t               scaled;

    assign prod   = pcm * $signed({1'b0, level});   // level is unsigned
    assign scaled = prod[23:8];                     // >>> 8, always fits 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left       <= '0;
            right      <= '0;
            sample_stb <= 1'b0;
        end else if (cen) begin
            sample_stb <= upd;
            if (upd) begin
                left  <= pan.left  ? scaled : '0;   // muted side reads 0
                right <= pan.right ? scaled : '0;
            end else if (!chon) begin
                // channel off, after any last sample has gone out
                left  <= '0;
                right <= '0;
            end
        end
    end

endmodule

// File: design/adpcmb_decoder.sv
// x moves 4 enabled cycles after adv is sampled; adv must be at least 5 enabled cycles apart
`timescale 1ns/1ps

module adpcmb_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  adpcmb_pkg::nibble_t  nibble,
    input  logic                 adv,       // nibble valid
    input  logic                 chon,      // low holds x and step at their idle values
    input  logic                 clr,       // restart, may come with adv
    output adpcmb_pkg::pcm_t     pcm,
    output logic                 upd
);
    import adpcmb_pkg::*;

    localparam logic signed [17:0] pcm_max = 18'sd32767;
    localparam logic signed [17:0] pcm_min = -18'sd32768;

    pcm_t               x;                  // waveform
    step_t              step;
    logic [3:0]         adv_pipe;           // tracks the nibble through the stages

    logic [3:0]         d2;                 // magnitude * 2 + 1
    logic               sign2;
    logic [18:0]        mult;               // d2 * step
    logic [22:0]        step_prod;          // step * factor
    logic [15:0]        d3;                 // offset magnitude, up to 46080
    logic [16:0]        next_step3;         // unclamped new step
    logic signed [17:0] d4;                 // signed offset
    logic signed [17:0] sum5;               // x + offset, before saturation

    assign mult      = d2 * step;
    assign step_prod = step_factor(d2[3:1]) * step;
    assign pcm       = x;

    // payload stages I to IV
    always_ff @(posedge clk) begin
        if (cen) begin
            if (adv) begin
                d2    <= {nibble[2:0], 1'b1};                         // I
                sign2 <= nibble[3];
            end
            d3         <= mult[18:3];                                 // II  / 8
            next_step3 <= step_prod[22:6];                            //     / 64
            d4         <= sign2 ? -$signed({2'b00, d3})               // III
                                :  $signed({2'b00, d3});
            sum5       <= x + d4;                                     // IV
        end
    end

    // stage V and the state that survives between nibbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x        <= '0;
            step     <= step_min;
            adv_pipe <= '0;
            upd      <= 1'b0;
        end else if (cen) begin
            adv_pipe <= {adv, clr ? 3'b000 : adv_pipe[3:1]};  // clr flushes older nibbles
            upd      <= 1'b0;
            if (!chon || clr) begin
                x    <= '0;
                step <= step_min;
            end else if (adv_pipe[0]) begin
                // saturate instead of wrapping
                if (sum5 > pcm_max) begin
                    x <= pcm_max[15:0];
                end else if (sum5 < pcm_min) begin
                    x <= pcm_min[15:0];
                end else begin
                    x <= sum5[15:0];
                end
                if (next_step3 < 17'(step_min)) begin
                    step <= step_min;
                end else if (next_step3 > 17'(step_max)) begin
                    step <= step_max;
                end else begin
                    step <= next_step3[14:0];
                end
                upd <= 1'b1;                // same edge as x
            end
        end
    end

endmodule

// File: design/adpcmb_fetch.sv
// needs delta <= 10922 and a synchronous-read memory; end_addr must be reachable from start_addr
`timescale 1ns/1ps

module adpcmb_fetch #(
    parameter int addr_w = adpcmb_pkg::default_addr_w
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 key_on,        // strobe, restarts from start_addr
    input  logic                 key_off,       // strobe, stops without eos
    input  logic                 repeat_en,     // loop back at end_addr
    input  logic [addr_w-1:0]    start_addr,
    input  logic [addr_w-1:0]    end_addr,      // last byte played, inclusive
    input  adpcmb_pkg::delta_t   delta,
    input  adpcmb_pkg::byte_t    mem_data,
    output logic [addr_w-1:0]    mem_addr,
    output adpcmb_pkg::nibble_t  nibble,
    output logic                 adv,
    output logic                 chon,
    output logic                 clr,
    output logic                 eos
);
    import adpcmb_pkg::*;

    fetch_state_e state;
    delta_t       phase;                        // rate accumulator
    logic [16:0]  phase_sum;                    // bit 16 is the nibble request
    byte_t        cur_byte;                     // byte whose low nibble is still due
    logic         low_next;                     // next nibble comes from the low half
    logic         wrap_pend;                    // next adv starts a new loop
    logic [2:0]   tail;                         // drain count after the last nibble
    logic         at_end;
    logic         take;                         // a nibble leaves this cycle

    assign phase_sum = {1'b0, phase} + {1'b0, delta};
    assign at_end    = (mem_addr == end_addr);
    assign take      = (state == st_play) && (tail == 3'd0) && phase_sum[16]
                       && !key_on && !key_off;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            mem_addr  <= '0;
            phase     <= '0;
            low_next  <= 1'b0;
            wrap_pend <= 1'b0;
            tail      <= '0;
            adv       <= 1'b0;
            chon      <= 1'b0;
            clr       <= 1'b0;
            eos       <= 1'b0;
        end else if (cen) begin
            adv <= 1'b0;                        // strobes last one enabled cycle
            clr <= 1'b0;
            eos <= 1'b0;
            if (key_on) begin
                state     <= st_load;
                mem_addr  <= start_addr;        // memory answers during st_load
                phase     <= '0;
                low_next  <= 1'b0;
                wrap_pend <= 1'b0;
                tail      <= '0;
                chon      <= 1'b1;
                clr       <= 1'b1;              // decoder starts from x 0, step_min
            end else if (key_off) begin
                state <= st_idle;
                chon  <= 1'b0;                  // in-flight decode is dropped
                tail  <= '0;
            end else begin
                case (state)
                    st_idle: chon <= 1'b0;
                    st_load: state <= st_play;
                    st_play: begin
                        if (tail != 3'd0) begin
                            // last decode lands on the cycle chon falls
                            if (tail == 3'd1) begin
                                chon  <= 1'b0;
                                eos   <= 1'b1;
                                state <= st_idle;
                            end
                            tail <= tail - 3'd1;
                        end else begin
                            phase <= phase_sum[15:0];
                            if (take) begin
                                adv       <= 1'b1;
                                clr       <= wrap_pend;   // restart clears the decoder
                                wrap_pend <= 1'b0;
                                low_next  <= !low_next;
                                if (low_next) begin
                                    if (!at_end) begin
                                        mem_addr <= mem_addr + 1'b1;    // prefetch next byte
                                    end else if (repeat_en) begin
                                        mem_addr  <= start_addr;
                                        wrap_pend <= 1'b1;
                                    end else begin
                                        // decoder samples adv 1 cycle later, then 4 stages
                                        tail <= 3'd5;
                                    end
                                end
                            end
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // nibble split, high half first
    always_ff @(posedge clk) begin
        if (cen && take) begin
            if (low_next) begin
                nibble <= cur_byte[3:0];
            end else begin
                nibble   <= mem_data[7:4];      // address has been stable for 6+ cycles
                cur_byte <= mem_data;
            end
        end
    end

endmodule

// File: design/adpcmb_pkg.sv
// shared widths and step table; step_factor only covers magnitudes 0 to 7 and is scaled by 1/64
package adpcmb_pkg;

    localparam int default_addr_w = 20;         // 1M x 8 sample memory

    typedef logic        [3:0]  nibble_t;        // sign + 3 bit magnitude
    typedef logic signed [15:0] pcm_t;           // waveform and output samples
    typedef logic        [14:0] step_t;          // adaptive step
    typedef logic        [7:0]  level_t;         // 255 is close to unity gain
    typedef logic        [15:0] delta_t;         // phase increment per enabled cycle
    typedef logic        [7:0]  byte_t;          // one sample memory byte

    // per-side output enables
    typedef struct packed {
        logic left;
        logic right;
    } pan_t;

    localparam step_t step_min = 15'd127;        // also the value after reset and clear
    localparam step_t step_max = 15'd24576;

    // step multiplier, applied as (step * factor) >> 6
    function automatic logic [7:0] step_factor(input logic [2:0] mag);
        logic [7:0] f;
        case (mag)
            3'd4:    f = 8'd77;
            3'd5:    f = 8'd102;
            3'd6:    f = 8'd128;
            3'd7:    f = 8'd153;
            default: f = 8'd57;                  // small codes shrink the step
        endcase
        return f;
    endfunction

    // fetch sequencing
    typedef enum logic [1:0] {
        st_idle,                                 // channel off
        st_load,                                 // first byte on its way from memory
        st_play                                  // accumulator running
    } fetch_state_e;

endpackage
